/* design/md_bus_pkg.sv */
// bus widths, payload types and strobe structs shared by the 68000 and Z80 bus resolvers
`default_nettype none

package md_bus_pkg;

	// main (68000) and sound (Z80) bus widths
	localparam int MAIN_DATA_W = 16;
	localparam int MAIN_ADDR_W = 23;
	localparam int SOUND_DATA_W = 8;
	localparam int SOUND_ADDR_W = 16;

	// work RAM address widths
	localparam int WRAM_ADDR_W = 15;
	localparam int ZRAM_ADDR_W = 13;

	typedef logic [MAIN_DATA_W-1:0] main_data_t;
	typedef logic [MAIN_ADDR_W-1:0] main_addr_t;
	typedef logic [SOUND_DATA_W-1:0] sound_data_t;
	typedef logic [SOUND_ADDR_W-1:0] sound_addr_t;

	// 68000 bus strobes, all active low
	typedef struct packed {
		logic as_n;
		logic uds_n;
		logic lds_n;
	} main_strb_t;

	// Z80 bus strobes, all active low
	typedef struct packed {
		logic rd_n;
		logic wr_n;
		logic mreq_n;
	} sound_strb_t;

	// what an undriven bus does
	typedef enum logic {
		IDLE_HOLD = 1'b0,
		IDLE_PULLUP = 1'b1
	} idle_mode_e;

	typedef struct packed {
		logic [WRAM_ADDR_W-1:0] addr;
		logic [1:0] be;
		main_data_t wdata;
		logic wren;
	} wram_port_t;

	typedef struct packed {
		logic [ZRAM_ADDR_W-1:0] addr;
		sound_data_t wdata;
		logic wren;
	} zram_port_t;

endpackage

`default_nettype wire

/* design/md_audio_pkg.sv */
// sample widths and types for the FM, 2612 DAC, PSG and mixed audio paths
`default_nettype none

package md_audio_pkg;

	localparam int FM_W = 9;
	localparam int DAC_W = 10;
	localparam int PSG_W = 16;
	localparam int MIX_W = 16;
	localparam int MIX2612_W = 18;

	// unsigned linear FM, signed 2612 DAC
	typedef logic [FM_W-1:0] fm_sample_t;
	typedef logic signed [DAC_W-1:0] dac_sample_t;
	typedef logic [PSG_W-1:0] psg_sample_t;

	typedef logic [MIX_W-1:0] mix_t;
	typedef logic [MIX2612_W-1:0] mix2612_t;

	// centre of the unsigned FM range
	localparam fm_sample_t FM_MIDPOINT = 9'd256;

endpackage

`default_nettype wire

/* design/bus_merge.sv */
// registered wired-OR resolver for a bus with several open-drain or tri-state drivers
`timescale 1ns/1ns
`default_nettype none

module bus_merge #(
	parameter type payload_t = logic,
	parameter int N_SRC = 2,
	parameter md_bus_pkg::idle_mode_e IDLE = md_bus_pkg::IDLE_HOLD
) (
	input wire MCLK2,
	input wire rst_n_i,
	input wire payload_t src_i [N_SRC],
	input wire payload_t src_off_i [N_SRC],
	output payload_t bus_o
);

	import md_bus_pkg::*;

	localparam int W = $bits(payload_t);
	localparam logic PULLUP = (IDLE == IDLE_PULLUP);

	logic [W-1:0] drv_or;
	logic [W-1:0] undriven;
	logic [W-1:0] bus_d;
	logic [W-1:0] bus_q;

	// per bit: OR of every driving source, and whether any source drives at all
	always_comb
	begin
		drv_or = '0;
		undriven = '1;
		for (int i = 0; i < N_SRC; i++)
		begin
			drv_or = drv_or | (src_i[i] & ~src_off_i[i]);
			undriven = undriven & src_off_i[i];
		end
	end

	// undriven bits either float high or keep the last value
	assign bus_d = drv_or | (undriven & (PULLUP ? {W{1'b1}} : bus_q));

	always_ff @(posedge MCLK2 or negedge rst_n_i)
	begin
		if (!rst_n_i)
			bus_q <= {W{PULLUP}};
		else
			bus_q <= bus_d;
	end

	assign bus_o = payload_t'(bus_q);

	// every driver pattern, including none, must resolve to known bits
	a_bus_known: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		!$isunknown(bus_q));

endmodule

`default_nettype wire

/* design/main_bus.sv */
// 68000-side bus resolution with work RAM and cartridge drivers, and the work RAM port
`timescale 1ns/1ns
`default_nettype none

module main_bus #(
	parameter md_bus_pkg::idle_mode_e HOLD_IDLE = md_bus_pkg::IDLE_HOLD,
	parameter md_bus_pkg::idle_mode_e STRB_IDLE = md_bus_pkg::IDLE_PULLUP
) (
	input wire MCLK2,
	input wire rst_n_i,
	input wire md_bus_pkg::main_data_t vdp_data_i,
	input wire md_bus_pkg::main_data_t vdp_data_off_i,
	input wire md_bus_pkg::main_data_t cpu_data_i,
	input wire md_bus_pkg::main_data_t cpu_data_off_i,
	input wire md_bus_pkg::main_addr_t vdp_addr_i,
	input wire md_bus_pkg::main_addr_t vdp_addr_off_i,
	input wire md_bus_pkg::main_addr_t cpu_addr_i,
	input wire md_bus_pkg::main_addr_t cpu_addr_off_i,
	input wire md_bus_pkg::main_strb_t vdp_strb_i,
	input wire md_bus_pkg::main_strb_t vdp_strb_off_i,
	input wire md_bus_pkg::main_strb_t cpu_strb_i,
	input wire md_bus_pkg::main_strb_t cpu_strb_off_i,
	input wire vdp_rw_i,
	input wire vdp_rw_off_i,
	input wire cpu_rw_i,
	input wire cpu_rw_off_i,
	input wire md_bus_pkg::main_data_t ram_q_i,
	input wire eoe_n_i,
	input wire noe_n_i,
	input wire ras0_n_i,
	input wire uwr_n_i,
	input wire lwr_n_i,
	input wire ia14_i,
	input wire md_bus_pkg::main_data_t cart_data_i,
	input wire cart_data_en_i,
	input wire m3_i,
	input wire cart_pause_i,
	input wire dtack_pull_i,
	input wire ext_dtack_i,
	input wire br_pull_i,
	input wire bgack_pull_i,
	output md_bus_pkg::main_data_t data_o,
	output md_bus_pkg::main_addr_t addr_o,
	output md_bus_pkg::main_strb_t strb_o,
	output logic rw_o,
	output logic dtack_n_o,
	output logic br_n_o,
	output logic bgack_n_o,
	output md_bus_pkg::wram_port_t wram_o,
	output logic cart_dma_o
);

	import md_bus_pkg::*;

	logic m3_q;
	main_data_t ram_off;
	main_data_t cart_off;
	main_addr_t ovl_addr;
	main_addr_t ovl_off;

	main_data_t data_src [4];
	main_data_t data_off [4];
	main_addr_t addr_src [3];
	main_addr_t addr_off [3];
	main_strb_t strb_src [2];
	main_strb_t strb_off [2];
	logic rw_src [2];
	logic rw_off [2];

	// RAM byte lanes open on their own output enable plus RAS0
	assign ram_off = {{8{eoe_n_i | ras0_n_i}}, {8{noe_n_i | ras0_n_i}}};

	// in Mark III mode the cartridge only reaches the low byte
	assign cart_off = m3_q ? {16{~cart_data_en_i}} : {8'hff, {8{~cart_data_en_i}}};

	// Mark III mode forces the top address bits
	assign ovl_addr = {~cart_pause_i, 1'b0, 1'b1, 20'h0};
	assign ovl_off = {{3{m3_q}}, 20'hfffff};

	// source order: video chip, 68000, work RAM, cartridge
	assign data_src = '{vdp_data_i, cpu_data_i, ram_q_i, cart_data_i};
	assign data_off = '{vdp_data_off_i, cpu_data_off_i, ram_off, cart_off};
	assign addr_src = '{vdp_addr_i, cpu_addr_i, ovl_addr};
	assign addr_off = '{vdp_addr_off_i, cpu_addr_off_i, ovl_off};
	assign strb_src = '{vdp_strb_i, cpu_strb_i};
	assign strb_off = '{vdp_strb_off_i, cpu_strb_off_i};
	assign rw_src = '{vdp_rw_i, cpu_rw_i};
	assign rw_off = '{vdp_rw_off_i, cpu_rw_off_i};

	bus_merge #(.payload_t(main_data_t), .N_SRC(4), .IDLE(HOLD_IDLE)) data_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(data_src),
		.src_off_i(data_off),
		.bus_o(data_o)
	);

	bus_merge #(.payload_t(main_addr_t), .N_SRC(3), .IDLE(HOLD_IDLE)) addr_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(addr_src),
		.src_off_i(addr_off),
		.bus_o(addr_o)
	);

	bus_merge #(.payload_t(main_strb_t), .N_SRC(2), .IDLE(STRB_IDLE)) strb_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(strb_src),
		.src_off_i(strb_off),
		.bus_o(strb_o)
	);

	bus_merge #(.payload_t(logic), .N_SRC(2), .IDLE(STRB_IDLE)) rw_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(rw_src),
		.src_off_i(rw_off),
		.bus_o(rw_o)
	);

	// pulled lines and the cartridge mode pin
	always_ff @(posedge MCLK2 or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			m3_q <= 1'b0;
			dtack_n_o <= 1'b1;
			br_n_o <= 1'b1;
			bgack_n_o <= 1'b1;
		end
		else
		begin
			m3_q <= m3_i;
			dtack_n_o <= ~(dtack_pull_i | ext_dtack_i);
			br_n_o <= ~br_pull_i;
			bgack_n_o <= ~bgack_pull_i;
		end
	end

	assign cart_dma_o = ~bgack_n_o;

	// A13 of the RAM comes from the video chip, not the bus
	assign wram_o.addr = {addr_o[14], ia14_i, addr_o[12:0]};
	assign wram_o.be = {~uwr_n_i, ~lwr_n_i};
	assign wram_o.wdata = data_o;
	assign wram_o.wren = (~uwr_n_i | ~lwr_n_i) & ~ras0_n_i;

	// a RAM byte lane is never read and written in the same RAS0 cycle
	a_wram_lane: assert property (@(posedge MCLK2) disable iff (!rst_n_i)
		!ras0_n_i |-> !((!uwr_n_i && !eoe_n_i) || (!lwr_n_i && !noe_n_i)));

endmodule

`default_nettype wire

/* design/sound_bus.sv */
// Z80-side bus resolution and the Z80 RAM port
`timescale 1ns/1ns
`default_nettype none

module sound_bus #(
	parameter md_bus_pkg::idle_mode_e DATA_IDLE = md_bus_pkg::IDLE_PULLUP,
	parameter md_bus_pkg::idle_mode_e ADDR_IDLE = md_bus_pkg::IDLE_HOLD,
	parameter md_bus_pkg::idle_mode_e STRB_IDLE = md_bus_pkg::IDLE_PULLUP
) (
	input wire MCLK2,
	input wire rst_n_i,
	input wire md_bus_pkg::sound_data_t vdp_data_i,
	input wire md_bus_pkg::sound_data_t vdp_data_off_i,
	input wire md_bus_pkg::sound_data_t z80_data_i,
	input wire md_bus_pkg::sound_data_t z80_data_off_i,
	input wire md_bus_pkg::sound_addr_t vdp_addr_i,
	input wire md_bus_pkg::sound_addr_t vdp_addr_off_i,
	input wire md_bus_pkg::sound_addr_t z80_addr_i,
	input wire md_bus_pkg::sound_addr_t z80_addr_off_i,
	input wire md_bus_pkg::sound_strb_t vdp_strb_i,
	input wire md_bus_pkg::sound_strb_t vdp_strb_off_i,
	input wire md_bus_pkg::sound_strb_t z80_strb_i,
	input wire md_bus_pkg::sound_strb_t z80_strb_off_i,
	input wire md_bus_pkg::sound_data_t zram_q_i,
	input wire zram_n_i,
	output md_bus_pkg::sound_data_t data_o,
	output md_bus_pkg::sound_addr_t addr_o,
	output md_bus_pkg::sound_strb_t strb_o,
	output md_bus_pkg::zram_port_t zram_o
);

	import md_bus_pkg::*;

	sound_data_t data_src [3];
	sound_data_t data_off [3];
	sound_addr_t addr_src [2];
	sound_addr_t addr_off [2];
	sound_strb_t strb_src [2];
	sound_strb_t strb_off [2];

	// Z80 RAM answers a resolved read while selected
	assign data_src = '{vdp_data_i, z80_data_i, zram_q_i};
	assign data_off = '{vdp_data_off_i, z80_data_off_i, {SOUND_DATA_W{strb_o.rd_n | zram_n_i}}};
	assign addr_src = '{vdp_addr_i, z80_addr_i};
	assign addr_off = '{vdp_addr_off_i, z80_addr_off_i};
	assign strb_src = '{vdp_strb_i, z80_strb_i};
	assign strb_off = '{vdp_strb_off_i, z80_strb_off_i};

	bus_merge #(.payload_t(sound_data_t), .N_SRC(3), .IDLE(DATA_IDLE)) data_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(data_src),
		.src_off_i(data_off),
		.bus_o(data_o)
	);

	bus_merge #(.payload_t(sound_addr_t), .N_SRC(2), .IDLE(ADDR_IDLE)) addr_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(addr_src),
		.src_off_i(addr_off),
		.bus_o(addr_o)
	);

	bus_merge #(.payload_t(sound_strb_t), .N_SRC(2), .IDLE(STRB_IDLE)) strb_merge_i (
		.MCLK2(MCLK2),
		.rst_n_i(rst_n_i),
		.src_i(strb_src),
		.src_off_i(strb_off),
		.bus_o(strb_o)
	);

	// 8K window, mirrored by the decoder upstream
	assign zram_o.addr = addr_o[ZRAM_ADDR_W-1:0];
	assign zram_o.wdata = data_o;
	assign zram_o.wren = ~zram_n_i & ~strb_o.wr_n;

endmodule

`default_nettype wire

/* design/audio_mix.sv */
// mixes the FM outputs with the PSG into the linear and 2612-style stereo pairs
`timescale 1ns/1ns
`default_nettype none

module audio_mix (
	input wire md_audio_pkg::fm_sample_t mol_i,
	input wire md_audio_pkg::fm_sample_t mor_i,
	input wire md_audio_pkg::dac_sample_t mol_2612_i,
	input wire md_audio_pkg::dac_sample_t mor_2612_i,
	input wire md_audio_pkg::psg_sample_t psg_i,
	output md_audio_pkg::mix_t a_l_o,
	output md_audio_pkg::mix_t a_r_o,
	output md_audio_pkg::mix2612_t a_l_2612_o,
	output md_audio_pkg::mix2612_t a_r_2612_o
);

	import md_audio_pkg::*;

	// recentre, sign-extend one bit, scale by 64, add PSG
	function automatic mix_t fm_mix(input fm_sample_t fm, input psg_sample_t psg);
		fm_sample_t fm_s;
		fm_s = fm - FM_MIDPOINT;
		return {fm_s[FM_W-1], fm_s, 6'h0} + psg;
	endfunction

	// DAC times 192 as x128 plus x64
	function automatic mix2612_t dac_mix(input dac_sample_t dac, input psg_sample_t psg);
		mix2612_t x128;
		mix2612_t x64;
		x128 = {dac[DAC_W-1], dac, 7'h0};
		x64 = {{2{dac[DAC_W-1]}}, dac, 6'h0};
		return x128 + x64 + {2'h0, psg};
	endfunction

	assign a_l_o = fm_mix(mol_i, psg_i);
	assign a_r_o = fm_mix(mor_i, psg_i);

	assign a_l_2612_o = dac_mix(mol_2612_i, psg_i);
	assign a_r_2612_o = dac_mix(mor_2612_i, psg_i);

endmodule

`default_nettype wire

/* design/md_glue.sv */
// board glue top level; chip bus drivers come in as ports, resolved buses and audio go out
`timescale 1ns/1ns
`default_nettype none

module md_glue #(
	parameter md_bus_pkg::idle_mode_e MAIN_IDLE = md_bus_pkg::IDLE_HOLD,
	parameter md_bus_pkg::idle_mode_e STRB_IDLE = md_bus_pkg::IDLE_PULLUP,
	parameter md_bus_pkg::idle_mode_e ZDATA_IDLE = md_bus_pkg::IDLE_PULLUP,
	parameter md_bus_pkg::idle_mode_e ZADDR_IDLE = md_bus_pkg::IDLE_HOLD
) (
	input wire MCLK2,
	input wire rst_n_i,
	// 68000 side
	input wire md_bus_pkg::main_data_t vdp_data_i,
	input wire md_bus_pkg::main_data_t vdp_data_off_i,
	input wire md_bus_pkg::main_data_t cpu_data_i,
	input wire md_bus_pkg::main_data_t cpu_data_off_i,
	input wire md_bus_pkg::main_addr_t vdp_addr_i,
	input wire md_bus_pkg::main_addr_t vdp_addr_off_i,
	input wire md_bus_pkg::main_addr_t cpu_addr_i,
	input wire md_bus_pkg::main_addr_t cpu_addr_off_i,
	input wire md_bus_pkg::main_strb_t vdp_strb_i,
	input wire md_bus_pkg::main_strb_t vdp_strb_off_i,
	input wire md_bus_pkg::main_strb_t cpu_strb_i,
	input wire md_bus_pkg::main_strb_t cpu_strb_off_i,
	input wire vdp_rw_i,
	input wire vdp_rw_off_i,
	input wire cpu_rw_i,
	input wire cpu_rw_off_i,
	input wire md_bus_pkg::main_data_t ram_q_i,
	input wire eoe_n_i,
	input wire noe_n_i,
	input wire ras0_n_i,
	input wire uwr_n_i,
	input wire lwr_n_i,
	input wire ia14_i,
	input wire md_bus_pkg::main_data_t cart_data_i,
	input wire cart_data_en_i,
	input wire m3_i,
	input wire cart_pause_i,
	input wire dtack_pull_i,
	input wire ext_dtack_i,
	input wire br_pull_i,
	input wire bgack_pull_i,
	// Z80 side
	input wire md_bus_pkg::sound_data_t snd_vdp_data_i,
	input wire md_bus_pkg::sound_data_t snd_vdp_data_off_i,
	input wire md_bus_pkg::sound_data_t z80_data_i,
	input wire md_bus_pkg::sound_data_t z80_data_off_i,
	input wire md_bus_pkg::sound_addr_t snd_vdp_addr_i,
	input wire md_bus_pkg::sound_addr_t snd_vdp_addr_off_i,
	input wire md_bus_pkg::sound_addr_t z80_addr_i,
	input wire md_bus_pkg::sound_addr_t z80_addr_off_i,
	input wire md_bus_pkg::sound_strb_t snd_vdp_strb_i,
	input wire md_bus_pkg::sound_strb_t snd_vdp_strb_off_i,
	input wire md_bus_pkg::sound_strb_t z80_strb_i,
	input wire md_bus_pkg::sound_strb_t z80_strb_off_i,
	input wire md_bus_pkg::sound_data_t zram_q_i,
	input wire zram_n_i,
	// audio sources
	input wire md_audio_pkg::fm_sample_t mol_i,
	input wire md_audio_pkg::fm_sample_t mor_i,
	input wire md_audio_pkg::dac_sample_t mol_2612_i,
	input wire md_audio_pkg::dac_sample_t mor_2612_i,
	input wire md_audio_pkg::psg_sample_t psg_i,
	// resolved 68000 bus
	output md_bus_pkg::main_data_t main_data_o,
	output md_bus_pkg::main_addr_t main_addr_o,
	output md_bus_pkg::main_strb_t main_strb_o,
	output logic main_rw_o,
	output logic dtack_n_o,
	output logic br_n_o,
	output logic bgack_n_o,
	output md_bus_pkg::wram_port_t wram_o,
	output logic cart_dma_o,
	output md_bus_pkg::main_addr_t cart_address_o,
	output md_bus_pkg::main_data_t cart_data_wr_o,
	// resolved Z80 bus
	output md_bus_pkg::sound_data_t snd_data_o,
	output md_bus_pkg::sound_addr_t snd_addr_o,
	output md_bus_pkg::sound_strb_t snd_strb_o,
	output md_bus_pkg::zram_port_t zram_o,
	// mixed audio
	output md_audio_pkg::mix_t a_l_o,
	output md_audio_pkg::mix_t a_r_o,
	output md_audio_pkg::mix2612_t a_l_2612_o,
	output md_audio_pkg::mix2612_t a_r_2612_o
);

	main_bus #(.HOLD_IDLE(MAIN_IDLE), .STRB_IDLE(STRB_IDLE)) main_bus_i (
		.*,
		.data_o(main_data_o),
		.addr_o(main_addr_o),
		.strb_o(main_strb_o),
		.rw_o(main_rw_o)
	);

	sound_bus #(.DATA_IDLE(ZDATA_IDLE), .ADDR_IDLE(ZADDR_IDLE), .STRB_IDLE(STRB_IDLE))
	sound_bus_i (
		.*,
		.vdp_data_i(snd_vdp_data_i),
		.vdp_data_off_i(snd_vdp_data_off_i),
		.vdp_addr_i(snd_vdp_addr_i),
		.vdp_addr_off_i(snd_vdp_addr_off_i),
		.vdp_strb_i(snd_vdp_strb_i),
		.vdp_strb_off_i(snd_vdp_strb_off_i),
		.data_o(snd_data_o),
		.addr_o(snd_addr_o),
		.strb_o(snd_strb_o)
	);

	audio_mix audio_mix_i (.*);

	// cartridge edge sees the resolved main bus directly
	assign cart_address_o = main_addr_o;
	assign cart_data_wr_o = main_data_o;

endmodule

`default_nettype wire

/* dv/glue_checker.sv */
// compares the resolved buses, RAM ports and audio of md_glue with the trace expectations
`timescale 1ns/1ns
`default_nettype none

module glue_checker #(
	parameter int SAMPLE_DELAY = 8
) (
	input wire MCLK2,
	input wire valid_i,
	input wire [7:0] test_i,
	input wire md_bus_pkg::main_data_t main_data_i,
	input wire md_bus_pkg::main_addr_t main_addr_i,
	input wire md_bus_pkg::main_strb_t main_strb_i,
	input wire [4:0] flags_i,
	input wire md_bus_pkg::wram_port_t wram_i,
	input wire md_bus_pkg::main_addr_t cart_address_i,
	input wire md_bus_pkg::main_data_t cart_data_wr_i,
	input wire md_bus_pkg::sound_data_t snd_data_i,
	input wire md_bus_pkg::sound_addr_t snd_addr_i,
	input wire md_bus_pkg::sound_strb_t snd_strb_i,
	input wire md_bus_pkg::zram_port_t zram_i,
	input wire md_audio_pkg::mix_t a_l_i,
	input wire md_audio_pkg::mix_t a_r_i,
	input wire md_audio_pkg::mix2612_t a_l_2612_i,
	input wire md_audio_pkg::mix2612_t a_r_2612_i,
	input wire md_bus_pkg::main_data_t exp_main_data_i,
	input wire md_bus_pkg::main_addr_t exp_main_addr_i,
	input wire md_bus_pkg::main_strb_t exp_main_strb_i,
	input wire [4:0] exp_flags_i,
	input wire md_bus_pkg::wram_port_t exp_wram_i,
	input wire md_bus_pkg::sound_data_t exp_snd_data_i,
	input wire md_bus_pkg::sound_addr_t exp_snd_addr_i,
	input wire md_bus_pkg::sound_strb_t exp_snd_strb_i,
	input wire md_bus_pkg::zram_port_t exp_zram_i,
	input wire md_audio_pkg::mix_t exp_a_l_i,
	input wire md_audio_pkg::mix_t exp_a_r_i,
	input wire md_audio_pkg::mix2612_t exp_a_l_2612_i,
	input wire md_audio_pkg::mix2612_t exp_a_r_2612_i,
	output int test_cnt_o,
	output int check_cnt_o,
	output int error_cnt_o
);

	int cur_test = 0;
	int test_cycles = 0;
	int test_errors = 0;
	int tests = 0;
	int checks = 0;
	int errors = 0;

	assign test_cnt_o = tests;
	assign check_cnt_o = checks;
	assign error_cnt_o = errors;

	task automatic compare(input string name, input logic [63:0] exp_v,
		input logic [63:0] act_v);
		checks++;
		if (act_v !== exp_v)
		begin
			$display("Fail at %0t ns: %s expected %0h got %0h", $time, name, exp_v, act_v);
			test_errors++;
			errors++;
		end
	endtask

	// one summary line for the test that just ended
	task automatic close_test();
		if (cur_test != 0)
		begin
			$display("test %0d: %0d cycles checked, %0d mismatches", cur_test, test_cycles,
				test_errors);
			tests++;
		end
		cur_test = 0;
	endtask

	// outputs are settled well before the next falling edge
	always @(posedge MCLK2)
	begin
		#SAMPLE_DELAY;
		if (valid_i)
		begin
			if (int'(test_i) != cur_test)
			begin
				close_test();
				cur_test = int'(test_i);
				test_cycles = 0;
				test_errors = 0;
			end
			test_cycles++;
			compare("main_data_o", exp_main_data_i, main_data_i);
			compare("main_addr_o", exp_main_addr_i, main_addr_i);
			compare("main_strb_o", exp_main_strb_i, main_strb_i);
			compare("main_rw_o", exp_flags_i[4], flags_i[4]);
			compare("dtack_n_o", exp_flags_i[3], flags_i[3]);
			compare("br_n_o", exp_flags_i[2], flags_i[2]);
			compare("bgack_n_o", exp_flags_i[1], flags_i[1]);
			compare("cart_dma_o", exp_flags_i[0], flags_i[0]);
			compare("wram_o", exp_wram_i, wram_i);
			compare("cart_address_o", exp_main_addr_i, cart_address_i);
			compare("cart_data_wr_o", exp_main_data_i, cart_data_wr_i);
			compare("snd_data_o", exp_snd_data_i, snd_data_i);
			compare("snd_addr_o", exp_snd_addr_i, snd_addr_i);
			compare("snd_strb_o", exp_snd_strb_i, snd_strb_i);
			compare("zram_o", exp_zram_i, zram_i);
			compare("a_l_o", exp_a_l_i, a_l_i);
			compare("a_r_o", exp_a_r_i, a_r_i);
			compare("a_l_2612_o", exp_a_l_2612_i, a_l_2612_i);
			compare("a_r_2612_o", exp_a_r_2612_i, a_r_2612_i);
		end
		else if (cur_test != 0)
			close_test();
	end

endmodule

`default_nettype wire

/* dv/tb_md_glue.sv */
// testbench top: reads the cycle trace, drives md_glue on the falling edge and reports the result
`timescale 1ns/1ns
`default_nettype none

module tb_md_glue;

	import md_bus_pkg::*;
	import md_audio_pkg::*;

	localparam string TRACE_FILE = "dv/glue_trace.txt";
	localparam int RESET_CYCLES = 4;
	localparam int SLACK_CYCLES = 20;

	logic MCLK2;
	logic rst_n_i;

	// 68000 side drivers
	main_data_t vdp_data_i, vdp_data_off_i, cpu_data_i, cpu_data_off_i;
	main_addr_t vdp_addr_i, vdp_addr_off_i, cpu_addr_i, cpu_addr_off_i;
	main_strb_t vdp_strb_i, vdp_strb_off_i, cpu_strb_i, cpu_strb_off_i;
	logic vdp_rw_i, vdp_rw_off_i, cpu_rw_i, cpu_rw_off_i;
	main_data_t ram_q_i;
	main_data_t cart_data_i;
	logic eoe_n_i, noe_n_i, ras0_n_i, uwr_n_i, lwr_n_i, ia14_i;
	logic cart_data_en_i, m3_i, cart_pause_i;
	logic dtack_pull_i, ext_dtack_i, br_pull_i, bgack_pull_i;

	// Z80 side drivers
	sound_data_t snd_vdp_data_i, snd_vdp_data_off_i, z80_data_i, z80_data_off_i;
	sound_addr_t snd_vdp_addr_i, snd_vdp_addr_off_i, z80_addr_i, z80_addr_off_i;
	sound_strb_t snd_vdp_strb_i, snd_vdp_strb_off_i, z80_strb_i, z80_strb_off_i;
	sound_data_t zram_q_i;
	logic zram_n_i;

	fm_sample_t mol_i, mor_i;
	dac_sample_t mol_2612_i, mor_2612_i;
	psg_sample_t psg_i;

	// DUT outputs
	main_data_t main_data_o, cart_data_wr_o;
	main_addr_t main_addr_o, cart_address_o;
	main_strb_t main_strb_o;
	logic main_rw_o, dtack_n_o, br_n_o, bgack_n_o, cart_dma_o;
	wram_port_t wram_o;
	sound_data_t snd_data_o;
	sound_addr_t snd_addr_o;
	sound_strb_t snd_strb_o;
	zram_port_t zram_o;
	mix_t a_l_o, a_r_o;
	mix2612_t a_l_2612_o, a_r_2612_o;

	// expected values of the current record
	logic [7:0] test_num;
	logic rec_valid;
	main_data_t exp_main_data;
	main_addr_t exp_main_addr;
	logic [2:0] exp_main_strb;
	logic [4:0] exp_flags;
	logic [$bits(wram_port_t)-1:0] exp_wram;
	sound_data_t exp_snd_data;
	sound_addr_t exp_snd_addr;
	logic [2:0] exp_snd_strb;
	logic [$bits(zram_port_t)-1:0] exp_zram;
	mix_t exp_a_l, exp_a_r;
	mix2612_t exp_a_l_2612, exp_a_r_2612;

	// running totals kept by the checker
	int n_tests;
	int n_checks;
	int n_errors;

	string s_lines[$];
	string z_lines[$];
	string e_lines[$];
	int trace_errs = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;
	bit load_ok;

	md_glue md_glue_i (.*);

	glue_checker checker_i (
		.MCLK2(MCLK2),
		.valid_i(rec_valid),
		.test_i(test_num),
		.main_data_i(main_data_o),
		.main_addr_i(main_addr_o),
		.main_strb_i(main_strb_o),
		.flags_i({main_rw_o, dtack_n_o, br_n_o, bgack_n_o, cart_dma_o}),
		.wram_i(wram_o),
		.cart_address_i(cart_address_o),
		.cart_data_wr_i(cart_data_wr_o),
		.snd_data_i(snd_data_o),
		.snd_addr_i(snd_addr_o),
		.snd_strb_i(snd_strb_o),
		.zram_i(zram_o),
		.a_l_i(a_l_o),
		.a_r_i(a_r_o),
		.a_l_2612_i(a_l_2612_o),
		.a_r_2612_i(a_r_2612_o),
		.exp_main_data_i(exp_main_data),
		.exp_main_addr_i(exp_main_addr),
		.exp_main_strb_i(exp_main_strb),
		.exp_flags_i(exp_flags),
		.exp_wram_i(exp_wram),
		.exp_snd_data_i(exp_snd_data),
		.exp_snd_addr_i(exp_snd_addr),
		.exp_snd_strb_i(exp_snd_strb),
		.exp_zram_i(exp_zram),
		.exp_a_l_i(exp_a_l),
		.exp_a_r_i(exp_a_r),
		.exp_a_l_2612_i(exp_a_l_2612),
		.exp_a_r_2612_i(exp_a_r_2612),
		.test_cnt_o(n_tests),
		.check_cnt_o(n_checks),
		.error_cnt_o(n_errors)
	);

	initial
	begin
		MCLK2 = 1'b0;
		forever #10 MCLK2 = ~MCLK2;
	end

	// every bus released, cartridge in normal mode
	task automatic idle_inputs();
		{vdp_data_i, cpu_data_i, ram_q_i, cart_data_i} = '0;
		{vdp_data_off_i, cpu_data_off_i} = '1;
		{vdp_addr_i, cpu_addr_i} = '0;
		{vdp_addr_off_i, cpu_addr_off_i} = '1;
		{vdp_strb_i, cpu_strb_i} = '0;
		{vdp_strb_off_i, cpu_strb_off_i} = '1;
		{vdp_rw_i, vdp_rw_off_i, cpu_rw_i, cpu_rw_off_i} = 4'b0101;
		{eoe_n_i, noe_n_i, ras0_n_i, uwr_n_i, lwr_n_i, ia14_i} = 6'b111110;
		{cart_data_en_i, m3_i, cart_pause_i} = 3'b010;
		{dtack_pull_i, ext_dtack_i, br_pull_i, bgack_pull_i} = '0;
		{snd_vdp_data_i, z80_data_i, zram_q_i} = '0;
		{snd_vdp_data_off_i, z80_data_off_i} = '1;
		{snd_vdp_addr_i, z80_addr_i} = '0;
		{snd_vdp_addr_off_i, z80_addr_off_i} = '1;
		{snd_vdp_strb_i, z80_strb_i} = '0;
		{snd_vdp_strb_off_i, z80_strb_off_i} = '1;
		zram_n_i = 1'b1;
		mol_i = FM_MIDPOINT;
		mor_i = FM_MIDPOINT;
		{mol_2612_i, mor_2612_i, psg_i} = '0;
	endtask

	// sorts the S, Z and E lines of the trace; comment lines fall through
	task automatic load_trace(output bit ok);
		int fd;
		string line;
		byte c;
		ok = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0)
		begin
			$display("cannot open trace file %s", TRACE_FILE);
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0)
			begin
				c = line.getc(0);
				case (c)
					"S": s_lines.push_back(line);
					"Z": z_lines.push_back(line);
					"E": e_lines.push_back(line);
					default: ;
				endcase
			end
		end
		$fclose(fd);
		if (s_lines.size() == 0)
			$display("trace file %s holds no records", TRACE_FILE);
		else if (s_lines.size() != z_lines.size() || s_lines.size() != e_lines.size())
			$display("trace file %s is short, its last record is incomplete", TRACE_FILE);
		else
			ok = 1'b1;
	endtask

	task automatic drive_record(input int idx);
		int n_s, n_z, n_e;
		int tnum;
		logic [11:0] mstrb, sstrb;
		logic [3:0] mrw;
		logic [5:0] mctl;
		logic [6:0] mctl2;
		n_s = $sscanf(s_lines[idx], "S %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h", tnum,
			vdp_data_i, vdp_data_off_i, cpu_data_i, cpu_data_off_i, vdp_addr_i,
			vdp_addr_off_i, cpu_addr_i, cpu_addr_off_i, mstrb, mrw, ram_q_i, mctl,
			cart_data_i, mctl2);
		n_z = $sscanf(z_lines[idx], "Z %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			snd_vdp_data_i, snd_vdp_data_off_i, z80_data_i, z80_data_off_i, snd_vdp_addr_i,
			snd_vdp_addr_off_i, z80_addr_i, z80_addr_off_i, sstrb, zram_q_i, zram_n_i,
			mol_i, mor_i, mol_2612_i, mor_2612_i, psg_i);
		n_e = $sscanf(e_lines[idx], "E %h %h %h %h %h %h %h %h %h %h %h %h %h",
			exp_main_data, exp_main_addr, exp_main_strb, exp_flags, exp_wram, exp_snd_data,
			exp_snd_addr, exp_snd_strb, exp_zram, exp_a_l, exp_a_r, exp_a_l_2612,
			exp_a_r_2612);
		if (n_s != 15 || n_z != 16 || n_e != 13)
		begin
			$display("trace record %0d could not be parsed", idx + 1);
			trace_errs++;
		end
		{vdp_strb_i, vdp_strb_off_i, cpu_strb_i, cpu_strb_off_i} = mstrb;
		{vdp_rw_i, vdp_rw_off_i, cpu_rw_i, cpu_rw_off_i} = mrw;
		{eoe_n_i, noe_n_i, ras0_n_i, uwr_n_i, lwr_n_i, ia14_i} = mctl;
		{cart_data_en_i, m3_i, cart_pause_i, dtack_pull_i, ext_dtack_i, br_pull_i,
			bgack_pull_i} = mctl2;
		{snd_vdp_strb_i, snd_vdp_strb_off_i, z80_strb_i, z80_strb_off_i} = sstrb;
		test_num = 8'(tnum);
	endtask

	// cycle limit from the trace length
	initial
	begin
		wait (cycle_limit > 0);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge MCLK2);
			cycle_cnt++;
		end
		$display("run timed out after %0d cycles", cycle_cnt);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		rst_n_i = 1'b0;
		rec_valid = 1'b0;
		test_num = '0;
		idle_inputs();
		load_trace(load_ok);
		if (!load_ok)
		begin
			$display("TESTBENCH FAILED");
			$finish;
		end
		else
		begin
			cycle_limit = s_lines.size() + RESET_CYCLES + SLACK_CYCLES;
			repeat (RESET_CYCLES) @(negedge MCLK2);
			rst_n_i = 1'b1;
			for (int i = 0; i < s_lines.size(); i++)
			begin
				@(negedge MCLK2);
				drive_record(i);
				rec_valid = 1'b1;
			end
			@(negedge MCLK2);
			rec_valid = 1'b0;
			// the checker closes the last test on the following rising edge
			@(negedge MCLK2);
			$display("%0d tests, %0d checks, %0d errors, %0d trace problems",
				n_tests, n_checks, n_errors, trace_errs);
			if (n_errors == 0 && trace_errs == 0 && n_tests > 0)
				$display("TESTBENCH PASSED");
			else
				$display("TESTBENCH FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dv/glue_trace.txt */
# one record per cycle: S = test vd vdo cd cdo va vao ca cao strb rw ramq ctl cart ctl2
# Z = svd svdo zd zdo sva svao za zao sstrb zq zn mol mor moll morr psg
# E = data addr strb flags(rw dtack br bgack dma) wram sdata saddr sstrb zram al ar al2 ar2
S 1 0000 ffff 1234 0000 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 1234 500000 7 1e 000002468 ff 0000 7 0001fe 0000 0000 00000 00000
S 1 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 abcd 16 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E ab34 500000 7 1e 000015668 ff 0000 7 0001fe 0000 0000 00000 00000
S 1 00f0 0000 0f01 0000 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 0ff1 500000 7 1e 000001fe2 ff 0000 7 0001fe 0000 0000 00000 00000
S 1 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 0ff1 500000 7 1e 000001fe2 ff 0000 7 0001fe 0000 0000 00000 00000
S 2 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 5a5a 60
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 5a5a 500000 7 1e 00000b4b4 ff 0000 7 0001fe 0000 0000 00000 00000
S 2 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 3c3c 50
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c3c 500000 7 1e 000007878 ff 0000 7 0001fe 0000 0000 00000 00000
S 2 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 9696 50
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 100000 7 1e 00000792c ff 0000 7 0001fe 0000 0000 00000 00000
S 2 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 500000 7 1e 00000792c ff 0000 7 0001fe 0000 0000 00000 00000
S 3 0000 ffff 0000 ffff 000000 7fffff 004123 000000 1d0 4 0000 3e 0000 28
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 2 06 20918792c ff 0000 7 0001fe 0000 0000 00000 00000
S 3 0000 ffff 0000 ffff 000000 7fffff 004123 000000 808 8 0000 3e 0000 26
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 5 12 20918792c ff 0000 7 0001fe 0000 0000 00000 00000
S 3 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 21
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 7 1d 20918792c ff 0000 7 0001fe 0000 0000 00000 00000
S 4 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 2345 0000 1d0 c3 0 100 100 000 000 0000
E 3c96 004123 7 1e 20918792c ff 2345 2 068bfe 0000 0000 00000 00000
S 4 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 2345 0000 1d0 c3 0 100 100 000 000 0000
E 3c96 004123 7 1e 20918792c c3 2345 2 068b86 0000 0000 00000 00000
S 4 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 5e 00 0000 ffff 2345 0000 1e0 c3 0 100 100 000 000 0000
E 3c96 004123 7 1e 20918792c df 2345 4 068bbf 0000 0000 00000 00000
S 4 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 5e 00 0000 ffff 2345 0000 1e0 c3 0 100 100 000 000 0000
E 3c96 004123 7 1e 20918792c 5e 2345 4 068abd 0000 0000 00000 00000
S 4 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 7 1e 20918792c ff 2345 7 068bfe 0000 0000 00000 00000
S 5 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 33 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 7 1e 3091c792d ff 2345 7 068bfe 0000 0000 00000 00000
S 5 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 38 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 7 1e 2091e792c ff 2345 7 068bfe 0000 0000 00000 00000
S 5 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 34 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 100 000 000 0000
E 3c96 004123 7 1e 2091a792d ff 2345 7 068bfe 0000 0000 00000 00000
S 6 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 1ff 000 3ff 200 0000
E 3c96 004123 7 1e 20918792c ff 2345 7 068bfe 3fc0 c000 3ff40 28000
S 6 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 100 0ff 0ff 001 f000
E 3c96 004123 7 1e 20918792c ff 2345 7 068bfe f000 efc0 1af40 0f0c0
S 6 0000 ffff 0000 ffff 000000 7fffff 000000 7fffff 1c7 5 0000 3e 0000 20
Z 00 ff 00 ff 0000 ffff 0000 ffff 1c7 00 1 000 100 000 3ff 4000
E 3c96 004123 7 1e 20918792c ff 2345 7 068bfe 0000 4000 04000 03f40

/* project.f */
design/md_bus_pkg.sv
design/md_audio_pkg.sv
design/bus_merge.sv
design/main_bus.sv
design/sound_bus.sv
design/audio_mix.sv
design/md_glue.sv
dv/glue_checker.sv
dv/tb_md_glue.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST ?= project.f
TB_TOP ?= tb_md_glue
RTL_TOP ?= md_glue
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
